/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [29:0] cache_addr_t;  // Byte address without the two low bits

    // Encoded as {funct7[5], funct3} so decode can pass the fields through
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_slt = 4'b0010,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src;       // Immediate as operand b
        logic    reg_write;
        logic    mem_to_reg;    // Loads only
        logic    mem_write;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs1_val;
        word_t     rs2_val;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_write;
        reg_addr_t rd;
        word_t     result;      // ALU result, also the data address
        word_t     store_data;
    } ex_mem_t;

    // Write-back port, we never set for x0
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    localparam word_t nop_inst = 32'h0000_0013;    // addi x0,x0,0

    // Bubble controls
    localparam ctrl_t ctrl_nop = '{alu_op: alu_and, default: '0};

endpackage

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  core_pkg::alu_op_e op,
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    output core_pkg::word_t   result
);
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {31'd0, $signed(a) < $signed(b)};
            alu_sll: result = a << shamt;
            alu_srl: result = a >> shamt;
            alu_sra: result = word_t'($signed(a) >>> shamt);
            default: result = a & b;    // alu_and and unused codes
        endcase
    end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                RST_n,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rs1_val,
    output core_pkg::word_t     rs2_val,
    input  core_pkg::wb_t       wb
);
    import core_pkg::*;

    word_t regs [32];

    // x0 stays zero since wb.we is never set for it
    always_ff @(posedge clk) begin
        if (!RST_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            RST_n,
    input  logic            hold,          // Cache stall or load-use bubble
    input  core_pkg::word_t icache_rdata,
    output core_pkg::word_t pc,
    output core_pkg::word_t inst           // IF/ID instruction register
);
    import core_pkg::*;

    word_t pc_next;

    assign pc_next = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            pc   <= RESET_PC;
            inst <= nop_inst;
        end else if (!hold) begin
            pc   <= pc_next;
            inst <= icache_rdata;   // Word fetched at the current pc
        end
    end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              RST_n,
    input  logic              stall,
    input  core_pkg::word_t   inst,
    input  core_pkg::wb_t     wb,
    output logic              hazard,
    output core_pkg::id_ex_t  id_ex
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_sh;
    word_t      rf_rs1;
    word_t      rf_rs2;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm;
    ctrl_t      ctrl;
    logic       uses_rs2;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_sh = {27'd0, inst[24:20]};

    reg_file u_reg_file (
        .clk     (clk),
        .RST_n   (RST_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_val (rf_rs1),
        .rs2_val (rf_rs2),
        .wb      (wb)
    );

    // Write lands this edge, so pass it straight through
    assign rs1_val = (wb.we && wb.rd == rs1) ? wb.data : rf_rs1;
    assign rs2_val = (wb.we && wb.rd == rs2) ? wb.data : rf_rs2;

    always_comb begin
        ctrl     = ctrl_nop;
        imm      = '0;
        uses_rs2 = 1'b0;
        case (opcode)
            op_reg: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_op_e'({inst[30], funct3});
                uses_rs2       = 1'b1;
            end
            op_imm: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin   // slli, srli, srai
                    imm         = imm_sh;
                    ctrl.alu_op = alu_op_e'({inst[30], funct3});
                end else begin
                    imm         = imm_i;
                    ctrl.alu_op = alu_op_e'({1'b0, funct3});
                end
            end
            op_load: begin
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_op     = alu_add;
                imm             = imm_i;
            end
            op_store: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_op    = alu_add;
                imm            = imm_s;
                uses_rs2       = 1'b1;
            end
            default: ;
        endcase
    end

    // Load in EX whose result is needed here
    assign hazard = id_ex.ctrl.mem_to_reg && (id_ex.rd != '0) &&
                    ((id_ex.rd == rs1) || (uses_rs2 && id_ex.rd == rs2));

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            id_ex <= '{ctrl: ctrl_nop, default: '0};
        end else if (!stall) begin
            id_ex.ctrl    <= hazard ? ctrl_nop : ctrl;
            id_ex.rs1_val <= rs1_val;
            id_ex.rs2_val <= rs2_val;
            id_ex.rs1     <= rs1;
            id_ex.rs2     <= rs2;
            id_ex.rd      <= rd;
            id_ex.imm     <= imm;
        end
    end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              RST_n,
    input  logic              stall,
    input  core_pkg::id_ex_t  id_ex,
    input  core_pkg::wb_t     wb,
    output core_pkg::ex_mem_t ex_mem
);
    import core_pkg::*;

    word_t op_a;
    word_t fwd_b;       // Also the store data
    word_t op_b;
    word_t alu_y;

    // Newest producer wins
    function automatic word_t forward(reg_addr_t src, word_t id_val);
        if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == src) begin
            return ex_mem.result;
        end else if (wb.we && wb.rd == src) begin
            return wb.data;
        end
        return id_val;
    endfunction

    always_comb begin
        op_a  = forward(id_ex.rs1, id_ex.rs1_val);
        fwd_b = forward(id_ex.rs2, id_ex.rs2_val);
        op_b  = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;
    end

    alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_y)
    );

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.result     <= alu_y;
            ex_mem.store_data <= fwd_b;
        end
    end

endmodule

`default_nettype wire

/* design/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic                  clk,
    input  logic                  RST_n,
    input  logic                  stall,
    input  core_pkg::ex_mem_t     ex_mem,
    output logic                  dcache_ren,
    output logic                  dcache_wen,
    output core_pkg::cache_addr_t dcache_addr,
    output core_pkg::word_t       dcache_wdata,
    input  core_pkg::word_t       dcache_rdata,
    output core_pkg::wb_t         wb
);
    import core_pkg::*;

    logic      mw_reg_write;
    logic      mw_mem_to_reg;
    reg_addr_t mw_rd;
    word_t     mw_result;
    word_t     mw_rdata;

    assign dcache_wen   = ex_mem.mem_write;
    assign dcache_ren   = ~ex_mem.mem_write;
    assign dcache_addr  = ex_mem.result[31:2];
    assign dcache_wdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            mw_reg_write  <= 1'b0;
            mw_mem_to_reg <= 1'b0;
        end else if (!stall) begin
            mw_reg_write  <= ex_mem.reg_write;
            mw_mem_to_reg <= ex_mem.mem_to_reg;
            mw_rd         <= ex_mem.rd;
            mw_result     <= ex_mem.result;
            mw_rdata      <= dcache_rdata;  // Valid once the stall drops
        end
    end

    assign wb.we   = mw_reg_write && (mw_rd != '0);
    assign wb.rd   = mw_rd;
    assign wb.data = mw_mem_to_reg ? mw_rdata : mw_result;

endmodule

`default_nettype wire

/* design/riscv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_pipeline #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  RST_n,
    // Instruction cache
    output core_pkg::cache_addr_t icache_addr,
    input  logic                  icache_stall,
    input  core_pkg::word_t       icache_rdata,
    // Data cache
    output logic                  dcache_ren,
    output logic                  dcache_wen,
    output core_pkg::cache_addr_t dcache_addr,
    output core_pkg::word_t       dcache_wdata,
    input  logic                  dcache_stall,
    input  core_pkg::word_t       dcache_rdata,
    output core_pkg::word_t       pc
);
    import core_pkg::*;

    logic    stall;
    logic    hold;
    logic    hazard;
    word_t   inst;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    wb_t     wb;

    assign stall       = icache_stall | dcache_stall;  // Freezes every stage
    assign hold        = stall | hazard;
    assign icache_addr = pc[31:2];

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .RST_n        (RST_n),
        .hold         (hold),
        .icache_rdata (icache_rdata),
        .pc           (pc),
        .inst         (inst)
    );

    decode_stage u_decode (
        .clk    (clk),
        .RST_n  (RST_n),
        .stall  (stall),
        .inst   (inst),
        .wb     (wb),
        .hazard (hazard),
        .id_ex  (id_ex)
    );

    execute_stage u_execute (
        .clk    (clk),
        .RST_n  (RST_n),
        .stall  (stall),
        .id_ex  (id_ex),
        .wb     (wb),
        .ex_mem (ex_mem)
    );

    memory_stage u_memory (
        .clk          (clk),
        .RST_n        (RST_n),
        .stall        (stall),
        .ex_mem       (ex_mem),
        .dcache_ren   (dcache_ren),
        .dcache_wen   (dcache_wen),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_rdata (dcache_rdata),
        .wb           (wb)
    );

endmodule

`default_nettype wire

/* tests/pipeline_props.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_props (
    input logic              clk,
    input logic              RST_n,
    input logic              stall,
    input core_pkg::id_ex_t  id_ex,
    input core_pkg::ex_mem_t ex_mem,
    input core_pkg::wb_t     wb
);
    import core_pkg::*;

    // EX/MEM frozen while either cache stalls
    assert property (@(posedge clk) disable iff (!RST_n) stall |=> $stable(ex_mem))
        else $error("EX/MEM changed during a stall");

    // A result for x0 never turns into a register write
    assert property (@(posedge clk) disable iff (!RST_n)
        (!stall && ex_mem.rd == '0) |=> !wb.we)
        else $error("Write-back enabled for x0");

    // Load-use pairs are always split by a bubble
    assert property (@(posedge clk) disable iff (!RST_n)
        !(ex_mem.mem_to_reg && ex_mem.rd != '0 && id_ex.ctrl != ctrl_nop &&
          (id_ex.rs1 == ex_mem.rd ||
           ((!id_ex.ctrl.alu_src || id_ex.ctrl.mem_write) && id_ex.rs2 == ex_mem.rd))))
        else $error("Instruction in EX uses the load just ahead of it");

endmodule

bind execute_stage pipeline_props u_props (
    .clk    (clk),
    .RST_n  (RST_n),
    .stall  (stall),
    .id_ex  (id_ex),
    .ex_mem (ex_mem),
    .wb     (wb)
);

`default_nettype wire

/* tests/tb_riscv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_pipeline;
    import core_pkg::*;

    localparam string CASE_FILE    = "tests/pipeline_cases.txt";
    localparam int    RESET_CYCLES = 4;
    localparam word_t RESET_PC     = 32'h0;

    logic        clk;
    logic        RST_n;
    cache_addr_t icache_addr;
    logic        icache_stall;
    word_t       icache_rdata;
    logic        dcache_ren;
    logic        dcache_wen;
    cache_addr_t dcache_addr;
    word_t       dcache_wdata;
    logic        dcache_stall;
    word_t       dcache_rdata;
    word_t       pc;

    word_t imem [256];
    word_t dmem [1024];

    // Case file entries in flat queues indexed by the per-test counts
    string test_name [$];
    int    stall_en_q [$];
    int    prog_len [$];
    int    data_cnt [$];
    int    store_cnt [$];
    word_t prog_q [$];
    word_t data_addr_q [$];
    word_t data_val_q [$];
    word_t exp_addr_q [$];
    word_t exp_data_q [$];

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          test_errors;
    int          stores_seen;
    int          exp_base;
    int          exp_total;
    int          budget;
    bit          running;
    bit          stall_en;
    string       cur_name;
    word_t       last_pc;
    cache_addr_t i_last;
    cache_addr_t d_last;
    logic        d_last_wen;
    int          i_left;
    int          d_left;

    riscv_pipeline #(
        .RESET_PC (RESET_PC)
    ) u_dut (
        .clk          (clk),
        .RST_n        (RST_n),
        .icache_addr  (icache_addr),
        .icache_stall (icache_stall),
        .icache_rdata (icache_rdata),
        .dcache_ren   (dcache_ren),
        .dcache_wen   (dcache_wen),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_stall (dcache_stall),
        .dcache_rdata (dcache_rdata),
        .pc           (pc)
    );

    always #5 clk = ~clk;

    // Instruction words past the memory read as nops
    assign icache_rdata = (icache_addr < 30'd256) ? imem[icache_addr[7:0]] : nop_inst;
    assign dcache_rdata = dmem[dcache_addr[9:0]];

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
        return b;
    endfunction

    function automatic int draw_stall_len();
        logic [1:0] v;
        v[0] = take_bit();
        v[1] = take_bit();
        return 1 + (int'(v) % 3);
    endfunction

    task automatic compare_value(string what, word_t expected, word_t actual);
        checks++;
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // Stall for 1 to 3 cycles on a new address or a rising write strobe
    always @(posedge clk) begin
        if (!RST_n || !stall_en) begin
            icache_stall <= 1'b0;
            dcache_stall <= 1'b0;
            i_left = 0;
            d_left = 0;
        end else begin
            if (i_left > 0) begin
                i_left = i_left - 1;
                icache_stall <= 1'b1;
            end else if (icache_addr != i_last) begin
                i_left = draw_stall_len() - 1;
                icache_stall <= 1'b1;
            end else begin
                icache_stall <= 1'b0;
            end
            if (d_left > 0) begin
                d_left = d_left - 1;
                dcache_stall <= 1'b1;
            end else if (dcache_addr != d_last || (dcache_wen && !d_last_wen)) begin
                d_left = draw_stall_len() - 1;
                dcache_stall <= 1'b1;
            end else begin
                dcache_stall <= 1'b0;
            end
        end
        i_last     <= icache_addr;
        d_last     <= dcache_addr;
        d_last_wen <= dcache_wen;
    end

    // A store counts on an edge where the whole pipeline moves
    always @(posedge clk) begin
        if (running && RST_n) begin
            if (pc != last_pc && pc != last_pc + 32'd4) begin
                $display("pc jumped from %h to %h in test %s", last_pc, pc, cur_name);
                errors++;
                test_errors++;
            end
            if (dcache_wen && !dcache_stall && !icache_stall) begin
                if (stores_seen >= exp_total) begin
                    $display("Unexpected extra store in test %s", cur_name);
                    errors++;
                    test_errors++;
                end else begin
                    compare_value($sformatf("%s store %0d address", cur_name, stores_seen),
                                  exp_addr_q[exp_base + stores_seen], {dcache_addr, 2'b00});
                    compare_value($sformatf("%s store %0d data", cur_name, stores_seen),
                                  exp_data_q[exp_base + stores_seen], dcache_wdata);
                    compare_value($sformatf("%s store %0d dcache_ren", cur_name, stores_seen),
                                  32'd0, {31'd0, dcache_ren});
                end
                dmem[dcache_addr[9:0]] <= dcache_wdata;
                stores_seen++;
            end
        end
        last_pc <= pc;
    end

    task automatic read_cases();
        int    fd;
        int    r;
        int    n;
        int    st;
        string tok;
        string line;
        string nm;
        word_t a;
        word_t v;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the case file %s", CASE_FILE);
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            n = test_name.size() - 1;
            if (tok.substr(0, 0) == "#") begin
                r = $fgets(line, fd);
            end else if (tok == "test") begin
                r = $fscanf(fd, "%s %d", nm, st);
                test_name.push_back(nm);
                stall_en_q.push_back(st);
                prog_len.push_back(0);
                data_cnt.push_back(0);
                store_cnt.push_back(0);
            end else if (tok == "i" && n >= 0) begin
                r = $fscanf(fd, "%h", v);
                prog_q.push_back(v);
                prog_len[n] = prog_len[n] + 1;
            end else if (tok == "d" && n >= 0) begin
                r = $fscanf(fd, "%h %h", a, v);
                data_addr_q.push_back(a);
                data_val_q.push_back(v);
                data_cnt[n] = data_cnt[n] + 1;
            end else if (tok == "s" && n >= 0) begin
                r = $fscanf(fd, "%h %h", a, v);
                exp_addr_q.push_back(a);
                exp_data_q.push_back(v);
                store_cnt[n] = store_cnt[n] + 1;
            end else begin
                $display("Unknown entry %s in the case file", tok);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(int t, int p_base, int d_base, int s_base);
        word_t a;
        word_t drain_pc;
        @(negedge clk);
        running = 1'b0;
        cur_name = test_name[t];
        test_errors = 0;
        @(posedge clk);
        RST_n <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog_len[t]) ? prog_q[p_base + i] : nop_inst;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] <= (word_t'(i) * 32'h9e37_79b9) ^ 32'h0f0f_0000;  // Background data per word
        end
        for (int i = 0; i < data_cnt[t]; i++) begin
            a = data_addr_q[d_base + i];
            dmem[a[11:2]] <= data_val_q[d_base + i];
        end
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        compare_value({cur_name, " reset pc"}, RESET_PC, pc);
        compare_value({cur_name, " reset dcache_wen"}, 32'd0, {31'd0, dcache_wen});
        compare_value({cur_name, " reset dcache_ren"}, 32'd1, {31'd0, dcache_ren});
        stall_en = (stall_en_q[t] != 0);
        exp_base = s_base;
        exp_total = store_cnt[t];
        stores_seen = 0;
        // Last instruction well past MEM so a repeated store is still caught
        drain_pc = RESET_PC + word_t'(4 * (prog_len[t] + 4));
        running = 1'b1;
        @(posedge clk);
        RST_n <= 1'b1;
        wait (stores_seen >= exp_total && pc >= drain_pc);
        $display("test %s finished, %0d stores, %0d errors", cur_name, stores_seen, test_errors);
    endtask

    // Watchdog budget of 16 cycles per instruction plus reset time per test
    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("Timeout, the tests did not finish within %0d cycles", budget);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int p_base;
        int d_base;
        int s_base;
        clk = 1'b0;
        RST_n = 1'b0;
        icache_stall = 1'b0;
        dcache_stall = 1'b0;
        lfsr = 32'h557070ea;
        errors = 0;
        checks = 0;
        budget = 0;
        running = 1'b0;
        stall_en = 1'b0;
        stores_seen = 0;
        exp_total = 0;
        exp_base = 0;
        read_cases();
        if (test_name.size() == 0) begin
            $display("No tests found in the case file");
            errors++;
        end
        for (int t = 0; t < test_name.size(); t++) begin
            budget = budget + prog_len[t] * 16 + RESET_CYCLES + 2;
        end
        p_base = 0;
        d_base = 0;
        s_base = 0;
        for (int t = 0; t < test_name.size(); t++) begin
            run_test(t, p_base, d_base, s_base);
            p_base = p_base + prog_len[t];
            d_base = d_base + data_cnt[t];
            s_base = s_base + store_cnt[t];
        end
        $display("%0d tests, %0d checks, %0d errors", test_name.size(), checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/pipeline_cases.txt */
# test <name> <stalls 0|1>, then i <instruction word> in program order from address 0,
# d <byte address> <initial data word>, s <byte address> <expected store data> in order
test alu_reg 0
i fec00093 i 00700113 i 002081b3 i 10302023 i 402081b3 i 10302023 i 002091b3 i 10302023
i 0020a1b3 i 10302023 i 0020c1b3 i 10302023 i 0020d1b3 i 10302023 i 4020d1b3 i 10302023
i 0020e1b3 i 10302023 i 0020f1b3 i 10302023
s 100 fffffff3 s 100 ffffffe5 s 100 fffff600 s 100 00000001 s 100 ffffffeb
s 100 01ffffff s 100 ffffffff s 100 ffffffef s 100 00000004
test alu_imm 1
i fec00093 i 06408193 i 10302023 i fff0a193 i 10302023 i 0f00c193 i 10302023 i 0030e193
i 10302023 i 07f0f193 i 10302023 i 00409193 i 10302023 i 01c0d193 i 10302023 i 4020d193
i 10302023
s 100 00000050 s 100 00000001 s 100 ffffff1c s 100 ffffffef s 100 0000006c
s 100 fffffec0 s 100 0000000f s 100 fffffffb
test forward 0
i 00500093 i 00108133 i fff00293 i 001101b3 i 10302023 i 10202223 i 10502423
s 100 0000000f s 104 0000000a s 108 ffffffff
test forward_stall 1
i 00500093 i 00108133 i fff00293 i 001101b3 i 10302023 i 10202223 i 10502423
s 100 0000000f s 104 0000000a s 108 ffffffff
test load_use 1
d 200 00001234 d 204 fffffff0
i 20002083 i 00108113 i 20402183 i 10302023 i 00310233 i 10402223 i 10202423
s 100 fffffff0 s 104 00001225 s 108 00001235
test x0_write 1
i 00900093 i 03708013 i 10002023 i 00108033 i 00000013 i 10002223 i 10102423
s 100 00000000 s 104 00000000 s 108 00000009

/* src.f */
design/core_pkg.sv
design/alu.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/riscv_pipeline.sv
tests/pipeline_props.sv
tests/tb_riscv_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_riscv_pipeline
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
